/* logic/rom_loader_pkg.sv */
// Shared constants and the phase type for the cartridge image loader
// Memory map assumes a 4 MB byte-addressed space with CHR in the upper half
package rom_loader_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus and counter widths
	//////////////////////////////////////////////////////////////////////

	localparam int ADDR_W  = 22;  // Byte address into cartridge memory
	localparam int DATA_W  = 8;
	localparam int FLAGS_W = 32;
	localparam int COUNT_W = 22;  // Holds 255 PRG pages of 16 KB

	// Size codes cover 1 to 128 pages and above
	localparam int SIZE_CODE_W = 3;

	//////////////////////////////////////////////////////////////////////
	// Memory layout
	//////////////////////////////////////////////////////////////////////

	localparam logic [ADDR_W-1:0] PRG_BASE = 22'h00_0000;
	localparam logic [ADDR_W-1:0] CHR_BASE = 22'h20_0000;  // Bit 21 set

	localparam int PRG_PAGE_SHIFT = 14;  // 16384-byte pages
	localparam int CHR_PAGE_SHIFT = 13;  // 8192-byte pages

	//////////////////////////////////////////////////////////////////////
	// iNES header
	//////////////////////////////////////////////////////////////////////

	localparam int HEADER_LEN = 16;

	// "NES" followed by end-of-file
	localparam logic [DATA_W-1:0] INES_MAGIC0 = 8'h4E;
	localparam logic [DATA_W-1:0] INES_MAGIC1 = 8'h45;
	localparam logic [DATA_W-1:0] INES_MAGIC2 = 8'h53;
	localparam logic [DATA_W-1:0] INES_MAGIC3 = 8'h1A;

	// Loader phases
	typedef enum logic [2:0] {
		S_HEADER = 3'd0,
		S_PRG    = 3'd1,
		S_CHR    = 3'd2,
		S_DONE   = 3'd3,
		S_ERROR  = 3'd4
	} loader_state_e;

endpackage

/* logic/byte_intake.sv */
// One-entry hold stage between the download stream and the loader
// Source may present a byte only while byte_wait is low
// A pending byte is dropped when a new load starts
`timescale 1ns/1ps

module byte_intake (
	input  logic                              clk,
	input  logic                              reset_nes,
	input  logic                              load_start,
	input  logic [rom_loader_pkg::DATA_W-1:0] byte_data,
	input  logic                              byte_valid,
	input  logic                              held_take,
	output logic                              held_valid,
	output logic [rom_loader_pkg::DATA_W-1:0] held_data,
	output logic                              byte_wait
);

	// Occupancy flag
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			held_valid <= 1'b0;
		end else if (byte_valid) begin
			held_valid <= 1'b1;
		end else if (load_start || held_take) begin
			held_valid <= 1'b0;  // Consumed or flushed
		end
	end

	// Byte store
	always_ff @(posedge clk) begin
		if (byte_valid) begin
			held_data <= byte_data;
		end
	end

	// Stall the source while the register is full
	assign byte_wait = held_valid;

	// Source must honor the stall or a byte gets overwritten
	a_no_byte_while_wait: assert property (
		@(posedge clk) disable iff (reset_nes)
		byte_valid |-> !byte_wait
	) else $error("byte_valid while byte_wait high");

endmodule

/* logic/ines_header_parser.sv */
// Header byte store and decode for iNES 1.0 and 2.0 images
// Outputs are combinational and only meaningful once all 16 bytes are in
// Dirty 1.0 headers lose the upper mapper nibble
`timescale 1ns/1ps

module ines_header_parser (
	input  logic                               clk,
	input  logic                               hdr_wr,
	input  logic [3:0]                         hdr_index,
	input  logic [rom_loader_pkg::DATA_W-1:0]  hdr_byte,
	input  logic                               invert_mirroring,
	output logic                               hdr_ok,
	output logic                               hdr_trainer,
	output logic [7:0]                         prg_pages,
	output logic [7:0]                         chr_pages,
	output logic [rom_loader_pkg::FLAGS_W-1:0] mapper_flags
);

	logic [rom_loader_pkg::DATA_W-1:0] ines [rom_loader_pkg::HEADER_LEN];

	logic                                  is_nes20;
	logic                                  is_dirty;
	logic [7:0]                            mapper;
	logic [7:0]                            submapper;
	logic [rom_loader_pkg::SIZE_CODE_W-1:0] prg_code;
	logic [rom_loader_pkg::SIZE_CODE_W-1:0] chr_code;
	logic                                  chr_ram;

	// Smallest n with pages <= 2**n, saturating at 7
	function automatic logic [rom_loader_pkg::SIZE_CODE_W-1:0] size_code(
		input logic [7:0] pages
	);
		logic [rom_loader_pkg::SIZE_CODE_W-1:0] code;
		code = 3'd7;
		for (int n = 6; n >= 0; n--) begin
			if ({1'b0, pages} <= (9'd1 << n)) begin
				code = 3'(n);
			end
		end
		return code;
	endfunction

	always_ff @(posedge clk) begin
		if (hdr_wr) begin
			ines[hdr_index] <= hdr_byte;
		end
	end

	///////////////////////////////////////////////////////////////////////
	// Field decode
	///////////////////////////////////////////////////////////////////////

	assign hdr_ok = (ines[0] == rom_loader_pkg::INES_MAGIC0) &&
	                (ines[1] == rom_loader_pkg::INES_MAGIC1) &&
	                (ines[2] == rom_loader_pkg::INES_MAGIC2) &&
	                (ines[3] == rom_loader_pkg::INES_MAGIC3);

	assign hdr_trainer = ines[6][2];  // 512-byte trainer is not supported

	assign prg_pages = ines[4];
	assign chr_pages = ines[5];

	assign is_nes20 = (ines[7][3:2] == 2'b10);

	// Garbage in bytes 9..15 points at an old ripper tag
	assign is_dirty = !is_nes20 &&
	                  ((ines[9][7:1] != 7'd0) ||
	                   (ines[10] != 8'd0) || (ines[11] != 8'd0) ||
	                   (ines[12] != 8'd0) || (ines[13] != 8'd0) ||
	                   (ines[14] != 8'd0) || (ines[15] != 8'd0));

	assign mapper    = {is_dirty ? 4'h0 : ines[7][7:4], ines[6][7:4]};
	assign submapper = is_nes20 ? ines[8] : 8'h00;

	assign prg_code = size_code(prg_pages);
	assign chr_code = size_code(chr_pages);
	assign chr_ram  = (chr_pages == 8'd0);

	// Flags word from high bits to low
	assign mapper_flags = {
		6'b0,
		ines[6][1],                     // Battery-backed saves
		submapper,
		ines[6][3],                     // Four-screen
		chr_ram,
		ines[6][0] ^ invert_mirroring,  // Mirroring
		chr_code,
		prg_code,
		mapper
	};

endmodule

/* logic/load_sequencer.sv */
// Loader phase control for header intake, then PRG and CHR payload writes
// One memory write in flight at a time and each byte waits for its ack
// Bytes past the end of the image are taken and dropped
`timescale 1ns/1ps

module load_sequencer (
	input  logic                              clk,
	input  logic                              reset_nes,
	input  logic                              load_start,
	input  logic                              held_valid,
	input  logic [rom_loader_pkg::DATA_W-1:0] held_data,
	output logic                              held_take,
	output logic                              hdr_wr,
	output logic [3:0]                        hdr_index,
	input  logic                              hdr_ok,
	input  logic                              hdr_trainer,
	input  logic [7:0]                        prg_pages,
	input  logic [7:0]                        chr_pages,
	output logic                              wr_req,
	output logic [rom_loader_pkg::ADDR_W-1:0] wr_addr,
	output logic [rom_loader_pkg::DATA_W-1:0] wr_data,
	input  logic                              wr_done,
	output logic                              busy,
	output logic                              done,
	output logic                              error
);

	rom_loader_pkg::loader_state_e state;

	logic [3:0]                         hdr_cnt;
	logic                               hdr_last;  // 16th byte just stored
	logic                               pending;
	logic [rom_loader_pkg::COUNT_W-1:0] count;
	logic [rom_loader_pkg::ADDR_W-1:0]  addr;
	logic [rom_loader_pkg::COUNT_W-1:0] prg_bytes;
	logic [rom_loader_pkg::COUNT_W-1:0] chr_bytes;
	logic                               phase_end;

	assign prg_bytes = {{(rom_loader_pkg::COUNT_W - 8){1'b0}}, prg_pages}
	                   << rom_loader_pkg::PRG_PAGE_SHIFT;
	assign chr_bytes = {{(rom_loader_pkg::COUNT_W - 8){1'b0}}, chr_pages}
	                   << rom_loader_pkg::CHR_PAGE_SHIFT;

	// Empty phase, or the last write completing now
	assign phase_end = (count == '0) || (wr_done && (count == 22'd1));

	always_comb begin
		held_take = 1'b0;
		wr_req    = 1'b0;
		case (state)
			rom_loader_pkg::S_HEADER: held_take = held_valid && !hdr_last;
			rom_loader_pkg::S_PRG, rom_loader_pkg::S_CHR: begin
				wr_req    = held_valid && !pending && (count != '0);
				held_take = wr_done;  // Byte freed once it is in memory
			end
			default: held_take = held_valid;
		endcase
	end

	assign hdr_wr    = (state == rom_loader_pkg::S_HEADER) && held_take;
	assign hdr_index = hdr_cnt;
	assign wr_addr   = addr;
	assign wr_data   = held_data;

	///////////////////////////////////////////////////////////////////////
	// Phase FSM
	///////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes || load_start) begin
			state    <= rom_loader_pkg::S_HEADER;
			hdr_cnt  <= 4'd0;
			hdr_last <= 1'b0;
			pending  <= 1'b0;
			count    <= '0;
			busy     <= 1'b0;
			done     <= 1'b0;
			error    <= 1'b0;
		end else begin
			if (wr_req) begin
				pending <= 1'b1;
			end else if (wr_done) begin
				pending <= 1'b0;
			end

			case (state)
				rom_loader_pkg::S_HEADER: begin
					if (hdr_wr) begin
						hdr_cnt <= hdr_cnt + 4'd1;
						if (hdr_cnt == rom_loader_pkg::HEADER_LEN - 1) begin
							hdr_last <= 1'b1;
							busy     <= 1'b1;
						end
					end
					// Parser outputs settle one cycle after the last byte
					if (hdr_last) begin
						hdr_last <= 1'b0;
						if (hdr_ok && !hdr_trainer) begin
							state <= rom_loader_pkg::S_PRG;
							addr  <= rom_loader_pkg::PRG_BASE;
							count <= prg_bytes;
						end else begin
							state <= rom_loader_pkg::S_ERROR;
							busy  <= 1'b0;
							done  <= 1'b1;
							error <= 1'b1;
						end
					end
				end
				rom_loader_pkg::S_PRG: begin
					if (phase_end) begin
						state <= rom_loader_pkg::S_CHR;
						addr  <= rom_loader_pkg::CHR_BASE;
						count <= chr_bytes;
					end else if (wr_done) begin
						count <= count - 22'd1;
						addr  <= addr + 22'd1;
					end
				end
				rom_loader_pkg::S_CHR: begin
					if (phase_end) begin
						state <= rom_loader_pkg::S_DONE;
						busy  <= 1'b0;
						done  <= 1'b1;
					end else if (wr_done) begin
						count <= count - 22'd1;
						addr  <= addr + 22'd1;
					end
				end
				default: ;  // Hold in done or error
			endcase
		end
	end

	// No second request until the write master reports the first
	a_single_write: assert property (
		@(posedge clk) disable iff (reset_nes || load_start)
		wr_req |=> (!wr_req until wr_done)
	) else $error("wr_req while a write is pending");

endmodule

/* logic/wb_write_master.sv */
// Wishbone classic single-write master writing one byte per bus cycle
// Caller must not request again before wr_done
`timescale 1ns/1ps

module wb_write_master (
	input  logic                              clk,
	input  logic                              reset_nes,
	input  logic                              wr_req,
	input  logic [rom_loader_pkg::ADDR_W-1:0] wr_addr,
	input  logic [rom_loader_pkg::DATA_W-1:0] wr_data,
	output logic                              wr_done,
	output logic                              wb_cyc,
	output logic                              wb_stb,
	output logic                              wb_we,
	output logic [rom_loader_pkg::ADDR_W-1:0] wb_adr,
	output logic [rom_loader_pkg::DATA_W-1:0] wb_dat,
	input  logic                              wb_ack
);

	// Cycle control
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we  <= 1'b0;
		end else if (wr_req && !wb_stb) begin
			wb_cyc <= 1'b1;
			wb_stb <= 1'b1;
			wb_we  <= 1'b1;
		end else if (wb_stb && wb_ack) begin
			wb_cyc <= 1'b0;  // Drops the cycle after ack
			wb_stb <= 1'b0;
			wb_we  <= 1'b0;
		end
	end

	// Address and data held for the whole cycle
	always_ff @(posedge clk) begin
		if (wr_req && !wb_stb) begin
			wb_adr <= wr_addr;
			wb_dat <= wr_data;
		end
	end

	assign wr_done = wb_stb && wb_ack;

	a_adr_stable: assert property (
		@(posedge clk) disable iff (reset_nes)
		(wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_dat))
	) else $error("Wishbone address or data changed before ack");

endmodule

/* logic/rom_loader_top.sv */
// Cartridge image loader, iNES only
// A rising edge on load_active restarts the load; memory is written over Wishbone
// mapper_flags is valid once done is high and error is low
`timescale 1ns/1ps

module rom_loader_top (
	input  logic                               clk,
	input  logic                               reset_nes,
	input  logic                               load_active,
	input  logic [rom_loader_pkg::DATA_W-1:0]  byte_data,
	input  logic                               byte_valid,
	input  logic                               invert_mirroring,
	input  logic                               wb_ack,
	output logic                               byte_wait,
	output logic                               wb_cyc,
	output logic                               wb_stb,
	output logic                               wb_we,
	output logic [rom_loader_pkg::ADDR_W-1:0]  wb_adr,
	output logic [rom_loader_pkg::DATA_W-1:0]  wb_dat,
	output logic [rom_loader_pkg::FLAGS_W-1:0] mapper_flags,
	output logic                               busy,
	output logic                               done,
	output logic                               error
);

	logic                              load_active_q;
	logic                              load_start;
	logic                              held_valid;
	logic [rom_loader_pkg::DATA_W-1:0] held_data;
	logic                              held_take;
	logic                              hdr_wr;
	logic [3:0]                        hdr_index;
	logic                              hdr_ok;
	logic                              hdr_trainer;
	logic [7:0]                        prg_pages;
	logic [7:0]                        chr_pages;
	logic                              wr_req;
	logic [rom_loader_pkg::ADDR_W-1:0] wr_addr;
	logic [rom_loader_pkg::DATA_W-1:0] wr_data;
	logic                              wr_done;

	// Start of a new download
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			load_active_q <= 1'b0;
		end else begin
			load_active_q <= load_active;
		end
	end

	assign load_start = load_active && !load_active_q;

	byte_intake u_intake (
		.clk        (clk),
		.reset_nes  (reset_nes),
		.load_start (load_start),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.held_take  (held_take),
		.held_valid (held_valid),
		.held_data  (held_data),
		.byte_wait  (byte_wait)
	);

	ines_header_parser u_parser (
		.clk              (clk),
		.hdr_wr           (hdr_wr),
		.hdr_index        (hdr_index),
		.hdr_byte         (held_data),  // Header bytes come straight from the hold register
		.invert_mirroring (invert_mirroring),
		.hdr_ok           (hdr_ok),
		.hdr_trainer      (hdr_trainer),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.mapper_flags     (mapper_flags)
	);

	load_sequencer u_seq (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.load_start  (load_start),
		.held_valid  (held_valid),
		.held_data   (held_data),
		.held_take   (held_take),
		.hdr_wr      (hdr_wr),
		.hdr_index   (hdr_index),
		.hdr_ok      (hdr_ok),
		.hdr_trainer (hdr_trainer),
		.prg_pages   (prg_pages),
		.chr_pages   (chr_pages),
		.wr_req      (wr_req),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.wr_done     (wr_done),
		.busy        (busy),
		.done        (done),
		.error       (error)
	);

	wb_write_master u_wb (
		.clk       (clk),
		.reset_nes (reset_nes),
		.wr_req    (wr_req),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.wr_done   (wr_done),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat    (wb_dat),
		.wb_ack    (wb_ack)
	);

endmodule

/* sim/tb_clock.sv */
// Free-running clock and power-on reset for the loader testbench
// Reset drops 10 ns after a rising edge, like the rest of the stimulus
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic reset_nes
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		reset_nes = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#10 reset_nes = 1'b0;
	end

endmodule

/* sim/loader_checker.sv */
// Scoreboard for the loader that follows the download stream and predicts
// every Wishbone write and the end-of-load status from the header it saw
// Samples on the rising edge, so stimulus must settle before it
`timescale 1ns/1ps

module loader_checker (
	input  logic                               clk,
	input  logic                               load_active,
	input  logic [rom_loader_pkg::DATA_W-1:0]  byte_data,
	input  logic                               byte_valid,
	input  logic                               invert_mirroring,
	input  logic                               wb_cyc,
	input  logic                               wb_stb,
	input  logic                               wb_we,
	input  logic [rom_loader_pkg::ADDR_W-1:0]  wb_adr,
	input  logic [rom_loader_pkg::DATA_W-1:0]  wb_dat,
	input  logic                               wb_ack,
	input  logic [rom_loader_pkg::FLAGS_W-1:0] mapper_flags,
	input  logic                               busy,
	input  logic                               done,
	input  logic                               error,
	input  logic                               check_req,  // End of one test
	input  logic                               report_req,
	input  int                                 test_num,
	output int                                 error_count
);

	logic [127:0]                       header;  // Byte k at bits 8k+7:8k
	logic                               load_q;
	int                                 hdr_seen;
	int                                 writes;
	int                                 total_writes;
	int                                 errors_at_start;
	int                                 tests_run;
	int                                 tests_failed;
	logic [rom_loader_pkg::ADDR_W-1:0]  e_addr;
	logic [rom_loader_pkg::DATA_W-1:0]  e_data;
	logic [rom_loader_pkg::FLAGS_W-1:0] e_flags;
	int                                 e_total;
	logic                               e_err;

	// Smallest n in 0..7 with pages <= 2**n
	function automatic logic [2:0] size_code_of(input logic [7:0] pages);
		int n;
		n = 0;
		while ((n < 7) && (int'(pages) > (1 << n))) begin
			n++;
		end
		return 3'(n);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic void predict_load(
		input  logic [127:0]                       h,
		input  logic                               inv,
		input  int                                 idx,
		output logic [rom_loader_pkg::ADDR_W-1:0]  exp_addr,
		output logic [rom_loader_pkg::DATA_W-1:0]  exp_data,
		output logic [rom_loader_pkg::FLAGS_W-1:0] exp_flags,
		output int                                 exp_total,
		output logic                               exp_err
	);
		logic [7:0] f6;
		logic [7:0] f7;
		logic       nes2;
		logic       dirty;
		int         prg_len;
		int         chr_len;
		f6 = h[55:48];
		f7 = h[63:56];
		exp_err = (h[31:0] != {rom_loader_pkg::INES_MAGIC3,
		                       rom_loader_pkg::INES_MAGIC2,
		                       rom_loader_pkg::INES_MAGIC1,
		                       rom_loader_pkg::INES_MAGIC0}) ||
		          f6[2];
		prg_len   = int'(h[39:32]) << rom_loader_pkg::PRG_PAGE_SHIFT;
		chr_len   = int'(h[47:40]) << rom_loader_pkg::CHR_PAGE_SHIFT;
		exp_total = exp_err ? 0 : prg_len + chr_len;
		if (idx < prg_len) begin
			exp_addr = rom_loader_pkg::PRG_BASE + 22'(idx);
		end else begin
			exp_addr = rom_loader_pkg::CHR_BASE + 22'(idx - prg_len);
		end
		exp_data = 8'(idx * 7);  // Payload pattern from the stimulus
		nes2  = (f7[3:2] == 2'b10);
		dirty = !nes2 && ((h[79:73] != 7'd0) || (h[127:80] != 48'd0));
		exp_flags        = '0;
		exp_flags[7:4]   = dirty ? 4'h0 : f7[7:4];
		exp_flags[3:0]   = f6[7:4];
		exp_flags[10:8]  = size_code_of(h[39:32]);
		exp_flags[13:11] = size_code_of(h[47:40]);
		exp_flags[14]    = f6[0] ^ inv;
		exp_flags[15]    = (h[47:40] == 8'd0);  // CHR RAM
		exp_flags[16]    = f6[3];
		exp_flags[24:17] = nes2 ? h[71:64] : 8'h00;
		exp_flags[25]    = f6[1];
	endfunction

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at %0t ns: test %0d, %s", $time, test_num, msg);
		error_count++;
	endtask

	initial begin
		header          = '0;
		load_q          = 1'b0;
		hdr_seen        = 0;
		writes          = 0;
		total_writes    = 0;
		errors_at_start = 0;
		tests_run       = 0;
		tests_failed    = 0;
		error_count     = 0;
	end

	always @(posedge clk) begin
		if (load_active && !load_q) begin  // New download
			header          = '0;
			hdr_seen        = 0;
			writes          = 0;
			errors_at_start = error_count;
		end
		load_q = load_active;

		if (byte_valid && (hdr_seen < rom_loader_pkg::HEADER_LEN)) begin
			header[8*hdr_seen +: 8] = byte_data;
			hdr_seen++;
		end

		if (wb_stb && wb_ack) begin
			predict_load(header, invert_mirroring, writes, e_addr, e_data, e_flags,
			             e_total, e_err);
			if (!wb_cyc || !wb_we) begin
				report_mismatch("strobe without cyc or we");
			end else if (!busy) begin
				report_mismatch($sformatf("write %0d while busy is low", writes));
			end else if (writes >= e_total) begin
				report_mismatch($sformatf("unexpected write %0d at %h", writes, wb_adr));
			end else if ((wb_adr !== e_addr) || (wb_dat !== e_data)) begin
				report_mismatch($sformatf("write %0d got %h=%h, expected %h=%h",
				                          writes, wb_adr, wb_dat, e_addr, e_data));
			end
			writes++;
			total_writes++;
		end

		if (check_req) begin
			predict_load(header, invert_mirroring, 0, e_addr, e_data, e_flags,
			             e_total, e_err);
			if (!done || busy) begin
				report_mismatch($sformatf("done=%b busy=%b at end of load", done, busy));
			end
			if (error !== e_err) begin
				report_mismatch($sformatf("error=%b, expected %b", error, e_err));
			end
			if (writes != e_total) begin
				report_mismatch($sformatf("%0d writes, expected %0d", writes, e_total));
			end
			if (!e_err && (mapper_flags !== e_flags)) begin
				report_mismatch($sformatf("flags %h, expected %h", mapper_flags, e_flags));
			end
			tests_run++;
			if (error_count == errors_at_start) begin
				$display("Test %0d passed: %0d writes, flags %h",
				         test_num, writes, mapper_flags);
			end else begin
				tests_failed++;
				$display("Test %0d FAILED: %0d errors",
				         test_num, error_count - errors_at_start);
			end
		end

		if (report_req) begin
			$display("Summary: %0d tests, %0d failed, %0d writes seen, %0d errors",
			         tests_run, tests_failed, total_writes, error_count);
		end
	end

endmodule

/* sim/rom_loader_tb.sv */
// Top-level testbench for the iNES loader
// Loads six images back to back, each followed by four spare bytes
// Memory model acks after 0 to 3 idle cycles drawn from an LFSR
`timescale 1ns/1ps

module rom_loader_tb;

	localparam int NUM_TESTS = 6;
	localparam int DRIVE_DLY = 10;  // ns after the rising edge
	localparam int SPARE     = 4;   // Bytes past the image end

	logic                               clk;
	logic                               reset_nes;
	logic                               load_active;
	logic [rom_loader_pkg::DATA_W-1:0]  byte_data;
	logic                               byte_valid;
	logic                               invert_mirroring;
	logic                               wb_ack;
	logic                               byte_wait;
	logic                               wb_cyc;
	logic                               wb_stb;
	logic                               wb_we;
	logic [rom_loader_pkg::ADDR_W-1:0]  wb_adr;
	logic [rom_loader_pkg::DATA_W-1:0]  wb_dat;
	logic [rom_loader_pkg::FLAGS_W-1:0] mapper_flags;
	logic                               busy;
	logic                               done;
	logic                               error;
	logic                               check_req;
	logic                               report_req;
	int                                 test_num;
	int                                 error_count;

	logic [127:0] headers [NUM_TESTS];
	logic         inverts [NUM_TESTS];
	logic [31:0]  lfsr;
	int           ack_delay;
	logic         in_cycle;
	int           cycle_count;
	int           cycle_limit;

	tb_clock u_clock (.clk(clk), .reset_nes(reset_nes));

	rom_loader_top DUT (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.load_active      (load_active),
		.byte_data        (byte_data),
		.byte_valid       (byte_valid),
		.invert_mirroring (invert_mirroring),
		.wb_ack           (wb_ack),
		.byte_wait        (byte_wait),
		.wb_cyc           (wb_cyc),
		.wb_stb           (wb_stb),
		.wb_we            (wb_we),
		.wb_adr           (wb_adr),
		.wb_dat           (wb_dat),
		.mapper_flags     (mapper_flags),
		.busy             (busy),
		.done             (done),
		.error            (error)
	);

	loader_checker u_checker (
		.clk              (clk),
		.load_active      (load_active),
		.byte_data        (byte_data),
		.byte_valid       (byte_valid),
		.invert_mirroring (invert_mirroring),
		.wb_cyc           (wb_cyc),
		.wb_stb           (wb_stb),
		.wb_we            (wb_we),
		.wb_adr           (wb_adr),
		.wb_dat           (wb_dat),
		.wb_ack           (wb_ack),
		.mapper_flags     (mapper_flags),
		.busy             (busy),
		.done             (done),
		.error            (error),
		.check_req        (check_req),
		.report_req       (report_req),
		.test_num         (test_num),
		.error_count      (error_count)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [127:0] make_header(
		input logic [7:0] prg,
		input logic [7:0] chr,
		input logic [7:0] f6,
		input logic [7:0] f7,
		input logic [7:0] f8,
		input logic [7:0] b12,
		input logic       bad_sig
	);
		logic [127:0] h;
		h          = '0;
		h[7:0]     = bad_sig ? 8'h4D : rom_loader_pkg::INES_MAGIC0;
		h[15:8]    = rom_loader_pkg::INES_MAGIC1;
		h[23:16]   = rom_loader_pkg::INES_MAGIC2;
		h[31:24]   = rom_loader_pkg::INES_MAGIC3;
		h[39:32]   = prg;
		h[47:40]   = chr;
		h[55:48]   = f6;
		h[63:56]   = f7;
		h[71:64]   = f8;
		h[103:96]  = b12;
		return h;
	endfunction

	// Image bytes after the header as the page counts say
	function automatic int payload_bytes(input logic [127:0] h);
		return (int'(h[39:32]) << rom_loader_pkg::PRG_PAGE_SHIFT) +
		       (int'(h[47:40]) << rom_loader_pkg::CHR_PAGE_SHIFT);
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// One-cycle byte_valid sent only while the intake is empty
	task automatic send_byte(input logic [7:0] b);
		while (byte_wait) begin
			next_cycle();
		end
		byte_data  = b;
		byte_valid = 1'b1;
		next_cycle();
		byte_valid = 1'b0;
	endtask

	task automatic run_test(input int n);
		int payload;
		payload          = payload_bytes(headers[n]);
		test_num         = n + 1;
		invert_mirroring = inverts[n];
		load_active      = 1'b1;
		repeat (2) next_cycle();
		for (int k = 0; k < rom_loader_pkg::HEADER_LEN; k++) begin
			send_byte(headers[n][8*k +: 8]);
		end
		for (int i = 0; i < payload + SPARE; i++) begin
			send_byte(8'(i * 7));
		end
		while (!(done && !byte_wait)) begin
			next_cycle();
		end
		check_req = 1'b1;
		next_cycle();
		check_req   = 1'b0;
		load_active = 1'b0;
		repeat (2) next_cycle();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Wishbone slave model
	//////////////////////////////////////////////////////////////////////

	initial begin
		wb_ack    = 1'b0;
		in_cycle  = 1'b0;
		ack_delay = 0;
		lfsr      = 32'hc89b;
		forever begin
			next_cycle();
			if (wb_ack) begin
				wb_ack   = 1'b0;  // Single-cycle ack
				in_cycle = 1'b0;
			end else if (wb_stb) begin
				if (!in_cycle) begin  // New write draws its wait
					in_cycle  = 1'b1;
					lfsr      = lfsr_step(lfsr);
					ack_delay = int'(lfsr[0]);
					lfsr      = lfsr_step(lfsr);
					ack_delay = ack_delay + 2 * int'(lfsr[0]);
				end
				if (ack_delay == 0) begin
					wb_ack = 1'b1;
				end else begin
					ack_delay--;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: loads did not finish within %0d cycles", cycle_limit);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		load_active      = 1'b0;
		byte_data        = '0;
		byte_valid       = 1'b0;
		invert_mirroring = 1'b0;
		check_req        = 1'b0;
		report_req       = 1'b0;
		test_num         = 0;
		cycle_count      = 0;
		headers[0] = make_header(8'd1, 8'd1, 8'h01, 8'h00, 8'h00, 8'h00, 1'b0);
		inverts[0] = 1'b0;
		headers[1] = make_header(8'd0, 8'd2, 8'h13, 8'h20, 8'h00, 8'h00, 1'b0);  // Mapper 0x21
		inverts[1] = 1'b1;
		headers[2] = make_header(8'd0, 8'd1, 8'h40, 8'h50, 8'h00, 8'h5A, 1'b0);  // Dirty
		inverts[2] = 1'b0;
		headers[3] = make_header(8'd0, 8'd1, 8'h00, 8'h00, 8'h00, 8'h00, 1'b1);  // Bad magic
		inverts[3] = 1'b0;
		headers[4] = make_header(8'd0, 8'd1, 8'h04, 8'h00, 8'h00, 8'h00, 1'b0);  // Trainer
		inverts[4] = 1'b0;
		headers[5] = make_header(8'd1, 8'd0, 8'h00, 8'h08, 8'h35, 8'h00, 1'b0);  // 2.0, CHR RAM
		inverts[5] = 1'b0;
		cycle_limit = 1000;
		for (int n = 0; n < NUM_TESTS; n++) begin
			cycle_limit += (rom_loader_pkg::HEADER_LEN + payload_bytes(headers[n]) + SPARE)
			               * 8;
		end

		@(negedge reset_nes);
		next_cycle();
		for (int n = 0; n < NUM_TESTS; n++) begin
			run_test(n);
		end
		report_req = 1'b1;
		next_cycle();
		report_req = 1'b0;
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* files.f */
logic/rom_loader_pkg.sv
logic/byte_intake.sv
logic/ines_header_parser.sv
logic/load_sequencer.sv
logic/wb_write_master.sv
logic/rom_loader_top.sv
sim/tb_clock.sv
sim/loader_checker.sv
sim/rom_loader_tb.sv
